/* common/ib_rom_pkg.sv */
`default_nettype none

package ib_rom_pkg;

	////////////////////////////////////////////////////////////
	// ib-rom geometry
	////////////////////////////////////////////////////////////

	localparam int ROM_RD_BW    = 6;  // one rom word, two table entries
	localparam int ROM_ADDR_BW  = 10; // 32 words per page, up to 32 pages
	localparam int PAGE_ADDR_BW = 5;  // word index inside one page
	localparam int ITER_ADDR_BW = 5;  // iteration index, selects the page
	localparam int ENTRY_BW     = 3;  // one quantized check node entry

	// pages are addressed as {iter, word}
	localparam int PAGE_WORDS = 1 << PAGE_ADDR_BW;

	////////////////////////////////////////////////////////////
	// rom word, seen whole or as an entry pair
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [ENTRY_BW-1:0] hi; // odd entry
		logic [ENTRY_BW-1:0] lo; // even entry
	} ib_pair_t;

	typedef union packed {
		logic [ROM_RD_BW-1:0] raw; // rom and latch view
		ib_pair_t             pair; // table memory view
	} ib_word_u;

endpackage

`default_nettype wire

/* common/cn_table_pkg.sv */
`default_nettype none

package cn_table_pkg;

	////////////////////////////////////////////////////////////
	// check node table geometry
	////////////////////////////////////////////////////////////

	// 64 entries per table at 2 entries per word
	localparam int ENTRY_ADDR_BW = 6;

	////////////////////////////////////////////////////////////
	// table write of one page word for both tables
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                                   en;        // write strobe
		logic [ib_rom_pkg::PAGE_ADDR_BW-1:0] page_addr; // word inside the page
		ib_rom_pkg::ib_word_u                   word_a;    // table a word
		ib_rom_pkg::ib_word_u                   word_b;    // table b word
	} cn_wr_t;

	////////////////////////////////////////////////////////////
	// table read of one entry from each table
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [ib_rom_pkg::ENTRY_BW-1:0] entry_a;
		logic [ib_rom_pkg::ENTRY_BW-1:0] entry_b;
	} cn_rd_t;

	// 18-bit write bus and 6-bit read bus
	localparam int CN_WR_BW = $bits(cn_wr_t);
	localparam int CN_RD_BW = $bits(cn_rd_t);

endpackage

`default_nettype wire

/* verilog/ib_rom.sv */
`default_nettype none

module ib_rom (
	input  wire                                  write_clk,
	input  wire  [ib_rom_pkg::ROM_ADDR_BW-1:0] addr,   // shared a/b address
	output ib_rom_pkg::ib_word_u                 data_a, // table a word
	output ib_rom_pkg::ib_word_u                 data_b  // table b word
);
	import ib_rom_pkg::*;

	localparam int ROM_DEPTH = 1 << ROM_ADDR_BW; // 1024 words per table

	ib_word_u rom_a [ROM_DEPTH]; // check node table a, all iterations
	ib_word_u rom_b [ROM_DEPTH]; // check node table b, all iterations

	logic [ROM_ADDR_BW-1:0] addr_q; // registered read address

	////////////////////////////////////////////////////////////
	// contents
	////////////////////////////////////////////////////////////

	// fixed arithmetic pattern in place of real ib tables
	initial begin
		for (int a = 0; a < ROM_DEPTH; a++) begin
			rom_a[a].raw = ROM_RD_BW'(a * 5 + 1); // low 6 bits only
			rom_b[a].raw = ROM_RD_BW'(a * 3 + 2);
		end
	end

	////////////////////////////////////////////////////////////
	// synchronous read
	////////////////////////////////////////////////////////////

	// bram style, address captured at the edge
	always_ff @(posedge write_clk) begin
		addr_q <= addr;
	end

	assign data_a = rom_a[addr_q]; // data valid one cycle after addr
	assign data_b = rom_b[addr_q];

endmodule

`default_nettype wire

/* cn_write/cn_mem_latch.sv */
`default_nettype none

module cn_mem_latch (
	input  wire                                   write_clk,
	input  wire                                   rstn,
	input  wire                                   fetch_load, // reload rom address
	input  wire  [ib_rom_pkg::ITER_ADDR_BW-1:0] iter,       // page to fetch
	output logic [ib_rom_pkg::ROM_ADDR_BW-1:0]  rom_addr,
	input  wire  ib_rom_pkg::ib_word_u            rom_data_a,
	input  wire  ib_rom_pkg::ib_word_u            rom_data_b,
	output ib_rom_pkg::ib_word_u                  latch_a,    // retimed table a word
	output ib_rom_pkg::ib_word_u                  latch_b     // retimed table b word
);
	import ib_rom_pkg::*;

	logic [ROM_ADDR_BW-1:0] page_base; // first word of the iteration's page

	////////////////////////////////////////////////////////////
	// rom read address
	////////////////////////////////////////////////////////////

	// iteration index in the upper bits, word index zeroed
	assign page_base = {iter, {PAGE_ADDR_BW{1'b0}}};

	// free running after the load
	// wraps past the page, the write window masks it
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			rom_addr <= '0;
		end else if (fetch_load) begin
			rom_addr <= page_base; // one shared address for a and b
		end else begin
			rom_addr <= rom_addr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// output latch
	////////////////////////////////////////////////////////////

	// breaks the rom output path before the table write
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			latch_a <= '0;
			latch_b <= '0;
		end else begin
			latch_a <= rom_data_a; // raw word, no decode here
			latch_b <= rom_data_b;
		end
	end

endmodule

`default_nettype wire

/* cn_write/cn_page_writer.sv */
`default_nettype none

module cn_page_writer (
	input  wire                       write_clk,
	input  wire                       rstn,
	input  wire                       wr_en,   // write window from control
	input  wire  ib_rom_pkg::ib_word_u latch_a,
	input  wire  ib_rom_pkg::ib_word_u latch_b,
	output cn_table_pkg::cn_wr_t      wr       // write to the shadow bank
);
	import ib_rom_pkg::*;

	logic [PAGE_ADDR_BW-1:0] page_addr; // word index inside the page

	////////////////////////////////////////////////////////////
	// page address counter
	////////////////////////////////////////////////////////////

	// starts at 0 on the first window cycle
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			page_addr <= '0;
		end else if (wr_en) begin
			page_addr <= page_addr + 1'b1; // 31 rolls back to 0
		end else begin
			page_addr <= '0; // idle, ready for the next page
		end
	end

	// write bundle, formed in the same cycle
	assign wr.en        = wr_en;
	assign wr.page_addr = page_addr;
	assign wr.word_a    = latch_a;
	assign wr.word_b    = latch_b;

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// one page per window, longer would overwrite word 0
	a_wr_window_len: assert property (
		@(posedge write_clk) disable iff (!rstn)
		wr_en [*PAGE_WORDS] |=> !wr_en
	) else $error("write window longer than one page");

endmodule

`default_nettype wire

/* cn_write/cn_table_mem.sv */
`default_nettype none

module cn_table_mem (
	input  wire                                     write_clk,
	input  wire                                     rstn,
	input  wire  cn_table_pkg::cn_wr_t              wr,          // shadow bank write
	input  wire                                     active_bank, // bank seen by decoder
	input  wire  [cn_table_pkg::ENTRY_ADDR_BW-1:0] rd_addr,     // entry index
	output cn_table_pkg::cn_rd_t                    rd_data
);
	import ib_rom_pkg::*;
	import cn_table_pkg::*;

	ib_word_u bank_a [2][PAGE_WORDS]; // table a, two banks
	ib_word_u bank_b [2][PAGE_WORDS]; // table b, two banks

	logic                    wr_bank;  // shadow bank
	logic [PAGE_ADDR_BW-1:0] rd_word;  // word holding the entry
	logic                    rd_hi;    // odd entry select
	ib_word_u                rd_word_a;
	ib_word_u                rd_word_b;

	////////////////////////////////////////////////////////////
	// write, shadow bank only
	////////////////////////////////////////////////////////////

	assign wr_bank = ~active_bank;

	always_ff @(posedge write_clk) begin
		if (wr.en) begin
			bank_a[wr_bank][wr.page_addr] <= wr.word_a;
			bank_b[wr_bank][wr.page_addr] <= wr.word_b;
		end
	end

	////////////////////////////////////////////////////////////
	// entry read, active bank
	////////////////////////////////////////////////////////////

	assign rd_word   = rd_addr[ENTRY_ADDR_BW-1:1];
	assign rd_hi     = rd_addr[0]; // even entry sits in lo
	assign rd_word_a = bank_a[active_bank][rd_word];
	assign rd_word_b = bank_b[active_bank][rd_word];

	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			rd_data <= '0;
		end else begin
			rd_data.entry_a <= rd_hi ? rd_word_a.pair.hi : rd_word_a.pair.lo;
			rd_data.entry_b <= rd_hi ? rd_word_b.pair.hi : rd_word_b.pair.lo;
		end
	end

	// whole page lands in one shadow bank, no swap mid-page
	a_wr_shadow_bank: assert property (
		@(posedge write_clk) disable iff (!rstn)
		wr.en && $past(wr.en) |-> active_bank == $past(active_bank)
	) else $error("bank swapped while a page was being written");

endmodule

`default_nettype wire

/* verilog/iter_update_ctrl.sv */
`default_nettype none

module iter_update_ctrl #(
	parameter int ITER_NUM = 25 // iterations held in the rom
) (
	input  wire                                   write_clk,
	input  wire                                   rstn,
	input  wire                                   start,       // update request strobe
	input  wire  [ib_rom_pkg::ITER_ADDR_BW-1:0] start_iter,  // requested iteration
	output logic [ib_rom_pkg::ITER_ADDR_BW-1:0] iter,        // captured iteration
	output logic                                  fetch_load,  // rom address reload
	output logic                                  wr_en,       // 32 cycle write window
	output logic                                  busy,
	output logic                                  done,        // update complete pulse
	output logic                                  iter_err,    // rejected start pulse
	output logic                                  active_bank  // decoder side bank
);
	localparam int PH_BW = 6;
	localparam logic [PH_BW-1:0] PH_FETCH    = 6'd1;  // rom address load
	localparam logic [PH_BW-1:0] PH_WR_FIRST = 6'd4;  // first latched word
	localparam logic [PH_BW-1:0] PH_WR_LAST  = 6'd35; // last word, bank swap
	localparam logic [PH_BW-1:0] PH_DONE     = 6'd36;

	logic [PH_BW-1:0] phase; // 0 idle, 1..36 update in flight
	logic             in_range;
	logic             start_ok;
	logic             start_bad;

	////////////////////////////////////////////////////////////
	// start check
	////////////////////////////////////////////////////////////

	assign in_range  = int'(start_iter) < ITER_NUM;
	assign start_ok  = start && !busy && in_range;  // starts while busy dropped
	assign start_bad = start && !busy && !in_range;

	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			phase       <= '0;
			iter        <= '0;
			iter_err    <= 1'b0;
			active_bank <= 1'b0;
		end else begin
			iter_err <= start_bad; // one cycle, nothing else moves
			if (start_ok) begin
				phase <= PH_FETCH;
				iter  <= start_iter;
			end else if (phase == PH_DONE) begin
				phase <= '0;
			end else if (phase != '0) begin
				phase <= phase + 1'b1;
			end
			// flip with the last write, new bank visible with done
			if (phase == PH_WR_LAST) active_bank <= ~active_bank;
		end
	end

	// strobes decoded from the phase
	assign busy       = (phase != '0) && (phase != PH_DONE);
	assign fetch_load = phase == PH_FETCH;
	assign wr_en      = (phase >= PH_WR_FIRST) && (phase <= PH_WR_LAST);
	assign done       = phase == PH_DONE;

	a_fetch_pulse: assert property (
		@(posedge write_clk) disable iff (!rstn) fetch_load |=> !fetch_load
	) else $error("fetch_load held longer than one cycle");

	a_done_pulse: assert property (
		@(posedge write_clk) disable iff (!rstn) done |=> !done
	) else $error("done held longer than one cycle");

	// rom latency plus one page of writes
	a_done_after_fetch: assert property (
		@(posedge write_clk) disable iff (!rstn) fetch_load |-> ##35 done
	) else $error("done did not follow fetch_load by 35 cycles");

endmodule

`default_nettype wire

/* verilog/cn_ib_update_top.sv */
`default_nettype none

module cn_ib_update_top #(
	parameter int ITER_NUM = 25 // iterations held in the rom
) (
	input  wire                                     write_clk,
	input  wire                                     rstn,
	input  wire                                     start,
	input  wire  [ib_rom_pkg::ITER_ADDR_BW-1:0]   start_iter,
	input  wire  [cn_table_pkg::ENTRY_ADDR_BW-1:0] rd_addr,
	output logic                                    busy,
	output logic                                    done,
	output logic                                    iter_err,
	output logic                                    active_bank,
	output cn_table_pkg::cn_rd_t                    rd_data
);
	import ib_rom_pkg::*;
	import cn_table_pkg::*;

	logic [ITER_ADDR_BW-1:0] iter;       // captured iteration
	logic                    fetch_load; // rom address reload
	logic                    wr_en;      // write window
	logic [ROM_ADDR_BW-1:0]  rom_addr;
	ib_word_u                rom_data_a, rom_data_b;
	ib_word_u                latch_a, latch_b; // retimed rom words
	cn_wr_t                  wr;         // page write to shadow bank

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	iter_update_ctrl #(.ITER_NUM(ITER_NUM)) iter_update_ctrl_i (
		.write_clk, .rstn, .start, .start_iter, .iter, .fetch_load,
		.wr_en, .busy, .done, .iter_err, .active_bank
	);

	////////////////////////////////////////////////////////////
	// rom fetch and table write
	////////////////////////////////////////////////////////////

	cn_mem_latch cn_mem_latch_i (
		.write_clk, .rstn, .fetch_load, .iter, .rom_addr,
		.rom_data_a, .rom_data_b, .latch_a, .latch_b
	);

	ib_rom ib_rom_i (.write_clk, .addr(rom_addr), .data_a(rom_data_a), .data_b(rom_data_b));

	cn_page_writer cn_page_writer_i (.write_clk, .rstn, .wr_en, .latch_a, .latch_b, .wr);

	cn_table_mem cn_table_mem_i (.write_clk, .rstn, .wr, .active_bank, .rd_addr, .rd_data);

endmodule

`default_nettype wire

/* dv/cn_ib_update_tb.sv */
`default_nettype none

module cn_ib_update_tb;
	import ib_rom_pkg::*;
	import cn_table_pkg::*;

	localparam int ITER_NUM   = 25;                // iterations held in the rom
	localparam int ITER_SPAN  = 1 << ITER_ADDR_BW; // all encodable indices
	localparam int DONE_CYCLE = 36;                // done, counted from the start edge
	localparam int UPDATES    = 10;
	localparam int DONE_WAIT  = 40;                // per update limit while waiting on done
	localparam int MAX_CYCLES = 2000;              // ~12 updates of 40 cycles plus read sweeps

	logic                     write_clk;
	logic                     rstn;
	logic                     start;
	logic [ITER_ADDR_BW-1:0]  start_iter;
	logic [ENTRY_ADDR_BW-1:0] rd_addr;
	logic                     busy;
	logic                     done;
	logic                     iter_err;
	logic                     active_bank;
	cn_rd_t                   rd_data;
	logic [CN_RD_BW-1:0]      rd_bits; // {entry_a, entry_b}

	int    seed;
	int    errors;
	int    cycle_cnt;
	int    reads_done;
	int    updates_done;
	string test_name;

	// reference model, moves on the rising edge
	int                      upd_elapsed; // 0 idle, else edges since the start edge plus one
	logic [ITER_ADDR_BW-1:0] upd_iter;
	logic [ITER_ADDR_BW-1:0] page_iter [2]; // iteration held by each bank
	logic [1:0]              page_ok;       // bank holds a full page
	logic                    exp_bank;
	logic                    exp_err;
	logic                    exp_busy;
	logic                    exp_done;
	logic                    rd_chk;        // read result is defined
	logic [CN_RD_BW-1:0]     exp_rd;

	cn_ib_update_top #(.ITER_NUM(ITER_NUM)) cn_ib_update_top_i (
		.write_clk, .rstn, .start, .start_iter, .rd_addr,
		.busy, .done, .iter_err, .active_bank, .rd_data
	);

	assign rd_bits = rd_data;

	initial begin
		write_clk = 1'b0;
		forever #10 write_clk = ~write_clk;
	end

	//////////////////////////////////////////////////////////////
	// reference entries from the rom rule
	//////////////////////////////////////////////////////////////

	// word w of table a is (5w+1) mod 64, table b (3w+2) mod 64
	function automatic logic [CN_RD_BW-1:0] entry_pair(
		input logic [ITER_ADDR_BW-1:0]  it,
		input logic [ENTRY_ADDR_BW-1:0] addr
	);
		int         word_addr;
		logic [5:0] wa;
		logic [5:0] wb;
		word_addr = (int'(it) << PAGE_ADDR_BW) + int'(addr >> 1); // page base plus word
		wa = 6'((word_addr * 5 + 1) % 64);
		wb = 6'((word_addr * 3 + 2) % 64);
		if (addr[0]) begin
			return {wa[5:3], wb[5:3]}; // odd entry in the upper half
		end else begin
			return {wa[2:0], wb[2:0]};
		end
	endfunction

	assign exp_busy = (upd_elapsed >= 1) && (upd_elapsed < DONE_CYCLE);
	assign exp_done = upd_elapsed == DONE_CYCLE;

	always @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			upd_elapsed  <= 0;
			upd_iter     <= '0;
			page_iter[0] <= '0;
			page_iter[1] <= '0;
			page_ok      <= '0;
			exp_bank     <= 1'b0;
			exp_err      <= 1'b0;
			rd_chk       <= 1'b0;
			exp_rd       <= '0;
		end else begin
			exp_err <= start && !exp_busy && (int'(start_iter) >= ITER_NUM);
			rd_chk  <= page_ok[exp_bank]; // bank before any swap at this edge
			exp_rd  <= entry_pair(page_iter[exp_bank], rd_addr);
			if (start && !exp_busy && (int'(start_iter) < ITER_NUM)) begin
				upd_elapsed <= 1;
				upd_iter    <= start_iter;
			end else if (upd_elapsed == DONE_CYCLE) begin
				upd_elapsed <= 0;
			end else if (upd_elapsed != 0) begin
				upd_elapsed <= upd_elapsed + 1;
			end
			// shadow page complete, it becomes visible with done
			if (upd_elapsed == DONE_CYCLE - 1) begin
				exp_bank            <= !exp_bank;
				page_iter[!exp_bank] <= upd_iter;
				page_ok[!exp_bank]   <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// checks, on the falling edge where outputs are settled
	//////////////////////////////////////////////////////////////

	a_reset_state: assert property (@(negedge write_clk)
		!rstn |-> !busy && !done && !iter_err && !active_bank)
	else begin
		errors++;
		$display("outputs are not idle while reset is held");
	end

	a_busy: assert property (@(negedge write_clk) disable iff (!rstn) busy == exp_busy)
	else begin
		errors++;
		$display("Fail %s busy: expected %0b, actual %0b", test_name, exp_busy, busy);
	end

	a_done: assert property (@(negedge write_clk) disable iff (!rstn) done == exp_done)
	else begin
		errors++;
		$display("Fail %s done: expected %0b, actual %0b", test_name, exp_done, done);
	end

	a_iter_err: assert property (@(negedge write_clk) disable iff (!rstn)
		iter_err == exp_err)
	else begin
		errors++;
		$display("Fail %s iter_err: expected %0b, actual %0b", test_name, exp_err, iter_err);
	end

	a_bank: assert property (@(negedge write_clk) disable iff (!rstn)
		active_bank == exp_bank)
	else begin
		errors++;
		$display("Fail %s active_bank: expected %0b, actual %0b",
			test_name, exp_bank, active_bank);
	end

	a_rd_data: assert property (@(negedge write_clk) disable iff (!rstn)
		rd_chk |-> rd_bits == exp_rd)
	else begin
		errors++;
		$display("Fail %s rd_data: expected %02h, actual %02h", test_name, exp_rd, rd_bits);
	end

	//////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////

	task automatic run_update(input logic [ITER_ADDR_BW-1:0] idx);
		int wait_cnt;
		test_name  = $sformatf("update iter %0d", idx);
		start      = 1'b1;
		start_iter = idx;
		@(negedge write_clk);
		start    = 1'b0;
		wait_cnt = 0;
		while (!done && wait_cnt < DONE_WAIT) begin
			rd_addr = ENTRY_ADDR_BW'(int'(rd_addr) + 1); // old page stays readable
			if (wait_cnt == 10) begin
				start      = 1'b1; // must be ignored while busy
				start_iter = ITER_ADDR_BW'($unsigned($random(seed)));
			end else begin
				start = 1'b0;
			end
			@(negedge write_clk);
			wait_cnt++;
		end
		start = 1'b0;
		if (!done) begin
			errors++;
			$display("done never came for the update of iteration %0d", idx);
		end
		updates_done++;
	endtask

	// every entry of both tables, one address per cycle
	task automatic sweep_reads(input logic [ITER_ADDR_BW-1:0] idx);
		test_name = $sformatf("read sweep iter %0d", idx);
		for (int a = 0; a < (1 << ENTRY_ADDR_BW); a++) begin
			rd_addr = ENTRY_ADDR_BW'(a);
			@(negedge write_clk);
			reads_done++;
		end
	endtask

	task automatic bad_start(input logic [ITER_ADDR_BW-1:0] idx);
		test_name  = $sformatf("bad start iter %0d", idx);
		start      = 1'b1;
		start_iter = idx;
		@(negedge write_clk);
		start = 1'b0;
		repeat (3) @(negedge write_clk); // iter_err shows, nothing else moves
	endtask

	initial begin : stimulus
		logic [ITER_ADDR_BW-1:0] idx;
		int                      pick;
		seed         = 32'h859a3a35;
		errors       = 0;
		cycle_cnt    = 0;
		reads_done   = 0;
		updates_done = 0;
		test_name    = "reset";
		rstn         = 1'b0;
		start        = 1'b0;
		start_iter   = '0;
		rd_addr      = '0;
		repeat (2) @(posedge write_clk);
		@(negedge write_clk);
		rstn      = 1'b1;
		test_name = "idle after reset";
		repeat (3) @(negedge write_clk);

		pick = $unsigned($random(seed)) % (ITER_SPAN - ITER_NUM);
		bad_start(ITER_ADDR_BW'(ITER_NUM + pick));
		for (int n = 0; n < UPDATES; n++) begin
			idx = ITER_ADDR_BW'($unsigned($random(seed)) % ITER_NUM);
			run_update(idx);
			sweep_reads(idx);
			if (n == UPDATES / 2) begin
				pick = $unsigned($random(seed)) % (ITER_SPAN - ITER_NUM);
				bad_start(ITER_ADDR_BW'(ITER_NUM + pick)); // between two updates
			end
		end
		repeat (2) @(negedge write_clk);

		$display("updates %0d, reads %0d, errors %0d", updates_done, reads_done, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog
	always @(posedge write_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			errors++;
			$display("timeout, run stopped after %0d cycles", cycle_cnt);
			$display("updates %0d, reads %0d, errors %0d", updates_done, reads_done, errors);
			$display("Regression failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* cn_ib_update.f */
common/ib_rom_pkg.sv
common/cn_table_pkg.sv
verilog/ib_rom.sv
cn_write/cn_mem_latch.sv
cn_write/cn_page_writer.sv
cn_write/cn_table_mem.sv
verilog/iter_update_ctrl.sv
verilog/cn_ib_update_top.sv
dv/cn_ib_update_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module cn_ib_update_tb \
	-f cn_ib_update.f -o cn_ib_update_sim > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/cn_ib_update_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
